// ==== include/nr_sync_defines.svh ====
`ifndef NR_SYNC_DEFINES_SVH
`define NR_SYNC_DEFINES_SVH

// frame geometry, scaled down from the real numerology
`define NR_FFT_LEN          16
`define NR_CP1_LEN          4
`define NR_CP2_LEN          3
`define NR_SYM_PER_SF       14

// sync blocks repeat every two subframes
`define NR_SYMS_BTWN_SSB    28

// one subframe is 14 * 16 useful samples plus 2 * 4 + 12 * 3 prefix samples = 268 clocks
`define NR_SSB_PERIOD_CLKS  536

// PSS detector wakes this early and keeps looking this long past the expected block
`define NR_PSS_EARLY_CLKS   16
`define NR_PSS_LATE_CLKS    16

// sample buffer in front of the FFT
`define NR_FIFO_DEPTH       32

`endif

// ==== verilog/nr_sync_pkg.sv ====
package nr_sync_pkg;

    // I in the upper half, Q in the lower half
    typedef struct packed {
        logic [15:0] i;
        logic [15:0] q;
    } sample_t;

    typedef logic [2:0] cp_len_t;

    typedef enum logic [1:0] {
        PSS_SEARCH = 2'd0,
        PSS_FIND   = 2'd1,
        PSS_PAUSE  = 2'd2
    } pss_mode_t;

    // FIFO payload, 36 bits
    typedef struct packed {
        sample_t data;
        logic    sym_start;
        cp_len_t cp_len;
    } tagged_sample_t;

endpackage

// ==== verilog/pss_mode_ctrl.sv ====
`timescale 1ns/1ps
`include "nr_sync_defines.svh"

module pss_mode_ctrl (
    input  logic                   clk_i,
    input  logic                   reset_ni,
    input  logic                   n_id_2_valid_i,
    output nr_sync_pkg::pss_mode_t pss_mode_o
);
    import nr_sync_pkg::*;

    localparam int WAKE_CLKS    = `NR_SSB_PERIOD_CLKS - `NR_PSS_EARLY_CLKS;
    localparam int GIVE_UP_CLKS = `NR_SSB_PERIOD_CLKS + `NR_PSS_LATE_CLKS;
    localparam int CNT_W        = $clog2(GIVE_UP_CLKS + 2);

    pss_mode_t        state_q;
    // clocks since the last detected sync block
    logic [CNT_W-1:0] clk_cnt_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q    <= PSS_SEARCH;
            clk_cnt_q  <= '0;
            pss_mode_o <= PSS_SEARCH;
        end else begin
            pss_mode_o <= state_q;
            case (state_q)
                PSS_SEARCH: begin
                    // any N_id_2 is accepted while searching
                    if (n_id_2_valid_i) begin
                        state_q   <= PSS_PAUSE;
                        clk_cnt_q <= CNT_W'(1);
                    end
                end
                PSS_PAUSE: begin
                    // detector sleeps until shortly before the next block
                    clk_cnt_q <= clk_cnt_q + 1'b1;
                    if (clk_cnt_q > CNT_W'(WAKE_CLKS)) begin
                        state_q <= PSS_FIND;
                    end
                end
                PSS_FIND: begin
                    if (n_id_2_valid_i) begin
                        state_q   <= PSS_PAUSE;
                        clk_cnt_q <= CNT_W'(1);
                    end else if (clk_cnt_q > CNT_W'(GIVE_UP_CLKS)) begin
                        // block missed, start over with a full search
                        state_q <= PSS_SEARCH;
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                default: state_q <= PSS_SEARCH;
            endcase
        end
    end

endmodule

// ==== verilog/symbol_timer.sv ====
`timescale 1ns/1ps
`include "nr_sync_defines.svh"

module symbol_timer (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  nr_sync_pkg::sample_t s_data_i,
    input  logic                 s_valid_i,
    input  logic [1:0]           n_id_2_i,
    input  logic                 n_id_2_valid_i,
    input  logic [2:0]           ibar_ssb_i,
    input  logic                 ibar_ssb_valid_i,
    output nr_sync_pkg::sample_t tag_data_o,
    output logic                 tag_sym_start_o,
    output nr_sync_pkg::cp_len_t tag_cp_len_o,
    output logic                 tag_valid_o,
    output logic                 pbch_start_o,
    output logic                 synced_o,
    output logic [1:0]           requested_n_id_2_o
);
    import nr_sync_pkg::*;

    localparam int FFT_LEN       = `NR_FFT_LEN;
    localparam int CP1_LEN       = `NR_CP1_LEN;
    localparam int CP2_LEN       = `NR_CP2_LEN;
    localparam int SYM_PER_SF    = `NR_SYM_PER_SF;
    localparam int SYMS_BTWN_SSB = `NR_SYMS_BTWN_SSB;
    localparam int SC_W          = $clog2(FFT_LEN + CP1_LEN);
    localparam int SYM_W         = $clog2(SYM_PER_SF);
    localparam int SUM_W         = SYM_W + 1;
    localparam int SSB_W         = $clog2(SYMS_BTWN_SSB);

    typedef enum logic [1:0] {
        ST_WAIT_SSB,
        ST_WAIT_IBAR,
        ST_SYNCED
    } timer_state_t;

    timer_state_t     state_q;
    logic [SC_W-1:0]  sc_q;
    logic [SYM_W-1:0] sym_q;
    // symbols since the last sync block, 0 on the block itself
    logic [SSB_W-1:0] ssb_sym_q;
    cp_len_t          cp_len_q;
    logic             find_q;

    logic             tracking;
    logic             lock;
    logic             ssb_hit;
    logic             ssb_miss;
    logic             open_find;
    logic [SC_W-1:0]  last_sc;
    logic             sym_end;
    logic [SUM_W-1:0] sym_sum;
    logic [SYM_W-1:0] sym_adj;
    logic [SYM_W-1:0] sym_next;

    function automatic cp_len_t cp_for_sym(input logic [SYM_W-1:0] sym);
        if (sym == '0 || sym == SYM_W'(SYM_PER_SF / 2)) begin
            return cp_len_t'(CP1_LEN);
        end
        return cp_len_t'(CP2_LEN);
    endfunction

    // ibar 1, 2 and 3 move the symbol index by 6, 14 and 20, taken modulo 14
    function automatic logic [SUM_W-1:0] ibar_shift(input logic [2:0] ibar);
        case (ibar)
            3'd1:    return SUM_W'(6);
            3'd2:    return SUM_W'(14 % SYM_PER_SF);
            3'd3:    return SUM_W'(20 % SYM_PER_SF);
            default: return '0;
        endcase
    endfunction

    always_comb begin
        tracking  = (state_q != ST_WAIT_SSB);
        lock      = (state_q == ST_WAIT_SSB) && n_id_2_valid_i;
        ssb_hit   = (state_q == ST_SYNCED) && find_q && n_id_2_valid_i;
        ssb_miss  = (state_q == ST_SYNCED) && find_q && !n_id_2_valid_i && (sc_q == SC_W'(3));
        last_sc   = SC_W'(FFT_LEN - 1) + SC_W'(cp_len_q);
        sym_end   = tracking && s_valid_i && (sc_q == last_sc);
        // window opens on the last-but-one sample before the expected block
        open_find = (state_q == ST_SYNCED) && s_valid_i && (sc_q == last_sc - 1'b1)
                    && (ssb_sym_q == SSB_W'(SYMS_BTWN_SSB - 1));
        // ibar correction lands before the symbol advance of the same cycle
        sym_sum = {1'b0, sym_q};
        if (state_q == ST_WAIT_IBAR && ibar_ssb_valid_i) begin
            sym_sum = sym_sum + ibar_shift(ibar_ssb_i);
        end
        if (sym_sum >= SUM_W'(SYM_PER_SF)) begin
            sym_adj = SYM_W'(sym_sum - SUM_W'(SYM_PER_SF));
        end else begin
            sym_adj = SYM_W'(sym_sum);
        end
        sym_next = (sym_adj == SYM_W'(SYM_PER_SF - 1)) ? '0 : sym_adj + 1'b1;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q            <= ST_WAIT_SSB;
            sc_q               <= '0;
            sym_q              <= '0;
            ssb_sym_q          <= '0;
            cp_len_q           <= cp_len_t'(CP2_LEN);
            find_q             <= 1'b0;
            tag_valid_o        <= 1'b0;
            pbch_start_o       <= 1'b0;
            requested_n_id_2_o <= '0;
        end else begin
            tag_valid_o  <= s_valid_i;
            pbch_start_o <= lock || ssb_hit;
            if (n_id_2_valid_i) begin
                requested_n_id_2_o <= n_id_2_i;
            end

            case (state_q)
                ST_WAIT_SSB: begin
                    // first block seen is taken as symbol 3 until ibar says otherwise
                    if (lock) begin
                        state_q   <= ST_WAIT_IBAR;
                        sym_q     <= SYM_W'(3);
                        ssb_sym_q <= '0;
                        cp_len_q  <= cp_len_t'(CP2_LEN);
                        sc_q      <= SC_W'(s_valid_i);
                    end
                end
                ST_WAIT_IBAR: begin
                    if (ibar_ssb_valid_i) begin
                        state_q <= ST_SYNCED;
                    end
                end
                ST_SYNCED: begin
                    if (ssb_miss) begin
                        state_q <= ST_WAIT_SSB;
                    end
                end
                default: state_q <= ST_WAIT_SSB;
            endcase

            if (tracking) begin
                if (sym_end) begin
                    sc_q      <= '0;
                    sym_q     <= sym_next;
                    cp_len_q  <= cp_for_sym(sym_next);
                    ssb_sym_q <= (ssb_sym_q == SSB_W'(SYMS_BTWN_SSB - 1)) ? '0 : ssb_sym_q + 1'b1;
                end else begin
                    sym_q <= sym_adj;
                    if (s_valid_i) begin
                        sc_q <= sc_q + 1'b1;
                    end
                end
            end

            if (ssb_hit || ssb_miss || state_q != ST_SYNCED) begin
                find_q <= 1'b0;
            end else if (open_find) begin
                find_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        tag_data_o      <= s_data_i;
        tag_sym_start_o <= lock || (tracking && sc_q == '0);
        tag_cp_len_o    <= lock ? cp_len_t'(CP2_LEN) : cp_len_q;
    end

    assign synced_o = (state_q == ST_SYNCED);

    sc_in_range: assert property (@(posedge clk_i) disable iff (!reset_ni)
        sc_q <= SC_W'(FFT_LEN + CP1_LEN - 1));

endmodule

// ==== verilog/tagged_sample_fifo.sv ====
`timescale 1ns/1ps
`include "nr_sync_defines.svh"

module tagged_sample_fifo #(
    parameter int DEPTH = `NR_FIFO_DEPTH
) (
    input  logic                         clk_i,
    input  logic                         reset_ni,
    input  nr_sync_pkg::tagged_sample_t  wr_data_i,
    input  logic                         wr_valid_i,
    input  logic                         hold_i,
    output nr_sync_pkg::tagged_sample_t  rd_data_o,
    output logic                         rd_valid_o,
    output logic                         overflow_o
);
    import nr_sync_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    tagged_sample_t   mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             rd_en;
    logic             wr_en;

    assign rd_en = (count_q != '0) && !hold_i;
    // when full, a write still fits if the head leaves in the same cycle
    assign wr_en = wr_valid_i && ((count_q != CNT_W'(DEPTH)) || rd_en);

    assign rd_valid_o = rd_en;
    assign rd_data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
        end else begin
            // pointers wrap on their own since DEPTH is a power of two
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // dropped sample, stays set until reset
            if (wr_valid_i && !wr_en) begin
                overflow_o <= 1'b1;
            end
        end
    end

    count_le_depth: assert property (@(posedge clk_i) disable iff (!reset_ni)
        count_q <= CNT_W'(DEPTH));

    no_underflow: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (count_q == '0) |=> (count_q <= CNT_W'(1)));

endmodule

// ==== verilog/cp_remover.sv ====
`timescale 1ns/1ps
`include "nr_sync_defines.svh"

module cp_remover (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  nr_sync_pkg::tagged_sample_t in_data_i,
    input  logic                        in_valid_i,
    output nr_sync_pkg::sample_t        fft_data_o,
    output logic                        fft_valid_o,
    output logic                        fft_sym_start_o
);
    import nr_sync_pkg::*;

    localparam int FFT_LEN = `NR_FFT_LEN;
    localparam int FWD_W   = $clog2(FFT_LEN + 1);

    // prefix samples still to drop
    cp_len_t          skip_q;
    // useful samples already sent in this symbol
    logic [FWD_W-1:0] sent_q;
    logic             start;
    logic             no_cp;
    logic             keep;

    always_comb begin
        start = in_valid_i && in_data_i.sym_start;
        no_cp = (in_data_i.cp_len == '0);
        if (start) begin
            keep = no_cp;
        end else begin
            keep = in_valid_i && (skip_q == '0) && (sent_q < FWD_W'(FFT_LEN));
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            skip_q          <= '0;
            // nothing leaves before the first tagged symbol start
            sent_q          <= FWD_W'(FFT_LEN);
            fft_valid_o     <= 1'b0;
            fft_sym_start_o <= 1'b0;
        end else begin
            fft_valid_o     <= keep;
            fft_sym_start_o <= keep && (start || sent_q == '0);
            if (start) begin
                skip_q <= no_cp ? '0 : in_data_i.cp_len - 1'b1;
                sent_q <= FWD_W'(no_cp);
            end else if (in_valid_i && skip_q != '0) begin
                skip_q <= skip_q - 1'b1;
            end else if (keep) begin
                sent_q <= sent_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (keep) begin
            fft_data_o <= in_data_i.data;
        end
    end

    // each output belongs to a symbol that has sent between 1 and FFT_LEN samples
    max_fft_len_per_symbol: assert property (@(posedge clk_i) disable iff (!reset_ni)
        fft_valid_o |-> (sent_q >= FWD_W'(1)) && (sent_q <= FWD_W'(FFT_LEN)));

endmodule

// ==== verilog/nr_sync_top.sv ====
`timescale 1ns/1ps
`include "nr_sync_defines.svh"

module nr_sync_top (
    input  logic                   clk_i,
    input  logic                   reset_ni,
    input  nr_sync_pkg::sample_t   s_data_i,
    input  logic                   s_valid_i,
    input  logic [1:0]             n_id_2_i,
    input  logic                   n_id_2_valid_i,
    input  logic [2:0]             ibar_ssb_i,
    input  logic                   ibar_ssb_valid_i,
    input  logic                   fft_hold_i,
    output nr_sync_pkg::pss_mode_t pss_mode_o,
    output logic [1:0]             requested_n_id_2_o,
    output logic                   pbch_start_o,
    output logic                   synced_o,
    output nr_sync_pkg::sample_t   fft_data_o,
    output logic                   fft_valid_o,
    output logic                   fft_sym_start_o,
    output logic                   overflow_o
);
    import nr_sync_pkg::*;

    sample_t        tag_data;
    logic           tag_sym_start;
    cp_len_t        tag_cp_len;
    logic           tag_valid;
    tagged_sample_t tag_word;
    tagged_sample_t rd_data;
    logic           rd_valid;

    assign tag_word = '{data: tag_data, sym_start: tag_sym_start, cp_len: tag_cp_len};

    pss_mode_ctrl pss_mode_ctrl_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_2_valid_i (n_id_2_valid_i),
        .pss_mode_o     (pss_mode_o)
    );

    symbol_timer symbol_timer_i (
        .clk_i              (clk_i),
        .reset_ni           (reset_ni),
        .s_data_i           (s_data_i),
        .s_valid_i          (s_valid_i),
        .n_id_2_i           (n_id_2_i),
        .n_id_2_valid_i     (n_id_2_valid_i),
        .ibar_ssb_i         (ibar_ssb_i),
        .ibar_ssb_valid_i   (ibar_ssb_valid_i),
        .tag_data_o         (tag_data),
        .tag_sym_start_o    (tag_sym_start),
        .tag_cp_len_o       (tag_cp_len),
        .tag_valid_o        (tag_valid),
        .pbch_start_o       (pbch_start_o),
        .synced_o           (synced_o),
        .requested_n_id_2_o (requested_n_id_2_o)
    );

    tagged_sample_fifo #(
        .DEPTH (`NR_FIFO_DEPTH)
    ) tagged_sample_fifo_i (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .wr_data_i  (tag_word),
        .wr_valid_i (tag_valid),
        .hold_i     (fft_hold_i),
        .rd_data_o  (rd_data),
        .rd_valid_o (rd_valid),
        .overflow_o (overflow_o)
    );

    cp_remover cp_remover_i (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .in_data_i       (rd_data),
        .in_valid_i      (rd_valid),
        .fft_data_o      (fft_data_o),
        .fft_valid_o     (fft_valid_o),
        .fft_sym_start_o (fft_sym_start_o)
    );

endmodule

// ==== verif/nr_sync_checker.sv ====
`timescale 1ns/1ps
`include "nr_sync_defines.svh"

module nr_sync_checker (
    input  logic        clk_i,
    input  logic        reset_ni,
    input  logic [31:0] s_data_i,
    input  logic        s_valid_i,
    input  logic [1:0]  n_id_2_i,
    input  logic        n_id_2_valid_i,
    input  logic [2:0]  ibar_ssb_i,
    input  logic        ibar_ssb_valid_i,
    input  logic        fft_hold_i,
    input  logic [1:0]  pss_mode_i,
    input  logic [1:0]  requested_n_id_2_i,
    input  logic        synced_i,
    input  logic        pbch_start_i,
    input  logic        overflow_i,
    input  logic [31:0] fft_data_i,
    input  logic        fft_valid_i,
    input  logic        fft_sym_start_i,
    input  logic        exp_valid_i,
    input  logic [2:0]  exp_kind_i,
    input  int          exp_val_i,
    output int          err_count_o
);
    // one tagged sample as the buffer holds it
    typedef struct packed {
        int         idx;
        logic       start;
        logic [2:0] cp;
    } entry_t;

    // one FFT sample still to come
    typedef struct packed {
        int   val;
        logic start;
    } fft_exp_t;

    int         errors = 0;
    // 0 unlocked, 1 waiting for ibar, 2 synced
    int         lock_state;
    int         sym;
    int         pos;
    int         cp;
    int         out_cnt;
    int         pbch_cnt;
    logic [1:0] nid_exp;
    // sample tagged on the previous edge, written to the buffer on this one
    logic       pend_valid;
    entry_t     pend;
    // model of the sample buffer in front of the FFT
    entry_t     buf_q[$];
    // prefix samples still to drop and useful samples still to send
    int         drop_left;
    int         send_left;
    fft_exp_t   fft_q[$];

    assign err_count_o = errors;

    function automatic int prefix_for(input int s);
        return (s == 0 || s == 7) ? `NR_CP1_LEN : `NR_CP2_LEN;
    endfunction

    function automatic int ibar_offset(input logic [2:0] ibar);
        case (ibar)
            3'd1:    return 6;
            3'd2:    return 14;
            3'd3:    return 20;
            default: return 0;
        endcase
    endfunction

    function automatic string kind_name(input logic [2:0] kind);
        case (kind)
            3'd0:    return "pss_mode";
            3'd1:    return "synced";
            3'd2:    return "overflow";
            3'd3:    return "pbch_start count";
            default: return "fft output count";
        endcase
    endfunction

    task automatic report(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        errors++;
    endtask

    always @(posedge clk_i) begin
        int       v;
        int       got;
        logic     pop;
        entry_t   e;
        fft_exp_t x;
        if (!reset_ni) begin
            lock_state = 0;
            sym        = 0;
            pos        = 0;
            cp         = `NR_CP2_LEN;
            out_cnt    = 0;
            pbch_cnt   = 0;
            nid_exp    = '0;
            pend_valid = 1'b0;
            pend       = '0;
            drop_left  = 0;
            send_left  = 0;
            buf_q.delete();
            fft_q.delete();
        end else begin
            // the last reported N_id_2 shows up one edge after its pulse
            if (requested_n_id_2_i != nid_exp) begin
                report($sformatf("requested N_id_2 %0d, expected %0d",
                                 requested_n_id_2_i, nid_exp));
            end
            if (n_id_2_valid_i) begin
                nid_exp = n_id_2_i;
            end
            if (pbch_start_i) begin
                pbch_cnt++;
            end

            // a popped useful sample leaves the prefix remover one edge later
            if (fft_valid_i) begin
                v = fft_data_i;
                out_cnt++;
                if (fft_q.size() == 0) begin
                    report($sformatf("FFT sample %0d where none was due", v));
                end else begin
                    x = fft_q.pop_front();
                    if (v != x.val) begin
                        report($sformatf("FFT sample %0d, expected %0d", v, x.val));
                    end
                    if (fft_sym_start_i != x.start) begin
                        report($sformatf("symbol start flag %0b on sample %0d, expected %0b",
                                         fft_sym_start_i, v, x.start));
                    end
                end
            end
            if (fft_q.size() != 0) begin
                report($sformatf("FFT sample %0d expected but not sent", fft_q[0].val));
                fft_q.delete();
            end

            // head leaves while the FFT does not hold, then the new sample goes in
            pop = (buf_q.size() != 0) && !fft_hold_i;
            if (pop) begin
                e = buf_q.pop_front();
                if (e.start) begin
                    drop_left = e.cp;
                    send_left = `NR_FFT_LEN;
                end
                if (drop_left > 0) begin
                    drop_left--;
                end else if (send_left > 0) begin
                    x.val   = e.idx;
                    x.start = (send_left == `NR_FFT_LEN);
                    fft_q.push_back(x);
                    send_left--;
                end
            end
            // a full buffer drops the sample
            if (pend_valid && buf_q.size() < `NR_FIFO_DEPTH) begin
                buf_q.push_back(pend);
            end

            // first block found is symbol 3, ibar then moves the numbering
            if (n_id_2_valid_i && lock_state == 0) begin
                lock_state = 1;
                sym        = 3;
                pos        = 0;
                cp         = `NR_CP2_LEN;
            end
            if (ibar_ssb_valid_i && lock_state == 1) begin
                lock_state = 2;
                sym        = (sym + ibar_offset(ibar_ssb_i)) % `NR_SYM_PER_SF;
            end
            pend_valid = s_valid_i;
            if (s_valid_i) begin
                pend.idx   = s_data_i;
                pend.start = (lock_state != 0) && (pos == 0);
                pend.cp    = 3'(cp);
                if (lock_state != 0) begin
                    pos++;
                    if (pos == `NR_FFT_LEN + cp) begin
                        pos = 0;
                        sym = (sym + 1) % `NR_SYM_PER_SF;
                        cp  = prefix_for(sym);
                    end
                end
            end

            if (exp_valid_i) begin
                case (exp_kind_i)
                    3'd0:    got = pss_mode_i;
                    3'd1:    got = synced_i;
                    3'd2:    got = overflow_i;
                    3'd3:    got = pbch_cnt;
                    default: got = out_cnt;
                endcase
                if (got != exp_val_i) begin
                    report($sformatf("%s expected %0d, got %0d",
                                     kind_name(exp_kind_i), exp_val_i, got));
                end
            end
        end
    end

endmodule

// ==== verif/nr_sync_tb.sv ====
`timescale 1ns/1ps

module nr_sync_tb;
    logic        clk_i;
    logic        reset_ni;
    logic [31:0] s_data;
    logic        s_valid;
    logic [1:0]  n_id_2;
    logic        n_id_2_valid;
    logic [2:0]  ibar_ssb;
    logic        ibar_ssb_valid;
    logic        fft_hold;
    logic [1:0]  pss_mode;
    logic [1:0]  requested_n_id_2;
    logic        pbch_start;
    logic        synced;
    logic [31:0] fft_data;
    logic        fft_valid;
    logic        fft_sym_start;
    logic        overflow;
    logic        exp_valid;
    logic [2:0]  exp_kind;
    int          exp_val;
    int          err_count;

    int          sample_idx;
    int          tests_run;
    int          tests_failed;
    int          test_errs;
    logic        aborted;
    logic        in_test;
    string       test_name;

    always #10 clk_i = ~clk_i;

    nr_sync_top dut_i (
        .clk_i              (clk_i),
        .reset_ni           (reset_ni),
        .s_data_i           (s_data),
        .s_valid_i          (s_valid),
        .n_id_2_i           (n_id_2),
        .n_id_2_valid_i     (n_id_2_valid),
        .ibar_ssb_i         (ibar_ssb),
        .ibar_ssb_valid_i   (ibar_ssb_valid),
        .fft_hold_i         (fft_hold),
        .pss_mode_o         (pss_mode),
        .requested_n_id_2_o (requested_n_id_2),
        .pbch_start_o       (pbch_start),
        .synced_o           (synced),
        .fft_data_o         (fft_data),
        .fft_valid_o        (fft_valid),
        .fft_sym_start_o    (fft_sym_start),
        .overflow_o         (overflow)
    );

    nr_sync_checker chk_i (
        .clk_i              (clk_i),
        .reset_ni           (reset_ni),
        .s_data_i           (s_data),
        .s_valid_i          (s_valid),
        .n_id_2_i           (n_id_2),
        .n_id_2_valid_i     (n_id_2_valid),
        .ibar_ssb_i         (ibar_ssb),
        .ibar_ssb_valid_i   (ibar_ssb_valid),
        .fft_hold_i         (fft_hold),
        .pss_mode_i         (pss_mode),
        .requested_n_id_2_i (requested_n_id_2),
        .synced_i           (synced),
        .pbch_start_i       (pbch_start),
        .overflow_i         (overflow),
        .fft_data_i         (fft_data),
        .fft_valid_i        (fft_valid),
        .fft_sym_start_i    (fft_sym_start),
        .exp_valid_i        (exp_valid),
        .exp_kind_i         (exp_kind),
        .exp_val_i          (exp_val),
        .err_count_o        (err_count)
    );

    // inputs change 2 ns after the rising edge
    task automatic step();
        @(posedge clk_i);
        #2;
    endtask

    task automatic apply_reset();
        reset_ni = 1'b0;
        for (int k = 0; k < 8; k++) begin
            step();
        end
        reset_ni = 1'b1;
    endtask

    task automatic stream(input int n, input logic hold);
        for (int k = 0; k < n; k++) begin
            s_valid  = 1'b1;
            s_data   = sample_idx;
            fft_hold = hold;
            sample_idx++;
            step();
        end
        s_valid  = 1'b0;
        fft_hold = 1'b0;
    endtask

    task automatic idle(input int n);
        for (int k = 0; k < n; k++) begin
            step();
        end
    endtask

    task automatic pulse_n_id_2(input int v);
        n_id_2       = v[1:0];
        n_id_2_valid = 1'b1;
        step();
        n_id_2_valid = 1'b0;
    endtask

    task automatic pulse_ibar(input int v);
        ibar_ssb       = v[2:0];
        ibar_ssb_valid = 1'b1;
        step();
        ibar_ssb_valid = 1'b0;
    endtask

    task automatic expect_value(input string what, input int val);
        case (what)
            "mode":   exp_kind = 3'd0;
            "synced": exp_kind = 3'd1;
            "ovf":    exp_kind = 3'd2;
            "pbch":   exp_kind = 3'd3;
            "fftcnt": exp_kind = 3'd4;
            default: begin
                $display("unknown check name %s in the trace", what);
                aborted = 1'b1;
            end
        endcase
        exp_val   = val;
        exp_valid = !aborted;
        step();
        exp_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int quiet;
        int guard;
        quiet = 0;
        guard = 0;
        while (quiet < 4 && guard < 2000) begin
            quiet = fft_valid ? 0 : quiet + 1;
            guard++;
            step();
        end
        if (quiet < 4) begin
            $display("timeout: FFT output still busy after 2000 cycles");
            aborted = 1'b1;
        end
    endtask

    task automatic close_test();
        if (in_test) begin
            tests_run++;
            if (err_count != test_errs) begin
                tests_failed++;
                $display("test %s: FAIL with %0d errors", test_name, err_count - test_errs);
            end else begin
                $display("test %s: ok", test_name);
            end
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    num;
        string line;
        string cmd;
        string word;
        clk_i          = 1'b0;
        reset_ni       = 1'b0;
        s_data         = '0;
        s_valid        = 1'b0;
        n_id_2         = '0;
        n_id_2_valid   = 1'b0;
        ibar_ssb       = '0;
        ibar_ssb_valid = 1'b0;
        fft_hold       = 1'b0;
        exp_valid      = 1'b0;
        exp_kind       = '0;
        exp_val        = 0;
        sample_idx     = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_errs      = 0;
        aborted        = 1'b0;
        in_test        = 1'b0;
        void'($urandom(35));
        apply_reset();

        fd = $fopen("verif/nr_sync_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file verif/nr_sync_trace.txt");
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted && !$feof(fd)) begin
            line = "";
            cmd  = "";
            word = "";
            num  = 0;
            n    = $fgets(line, fd);
            if (n > 0) begin
                n = $sscanf(line, "%s", cmd);
            end
            if (cmd == "C" || cmd == "T") begin
                n = $sscanf(line, "%s %s %d", cmd, word, num);
            end else if (cmd.len() > 0) begin
                n = $sscanf(line, "%s %d", cmd, num);
            end
            case (cmd)
                "", "#": ;
                "T": begin
                    close_test();
                    in_test   = 1'b1;
                    test_errs = err_count;
                    test_name = word;
                end
                "R": apply_reset();
                "S": stream(num, 1'b0);
                "H": stream(num, 1'b1);
                "W": idle(num);
                "G": idle($urandom_range(8, 1));
                "N": pulse_n_id_2(num);
                "I": pulse_ibar(num);
                "D": wait_drain();
                "C": expect_value(word, num);
                default: begin
                    $display("unknown trace command %s", cmd);
                    aborted = 1'b1;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        close_test();
        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
                 err_count);
        if (aborted || err_count != 0 || tests_failed != 0) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
verilog/nr_sync_pkg.sv
verilog/pss_mode_ctrl.sv
verilog/symbol_timer.sv
verilog/tagged_sample_fifo.sv
verilog/cp_remover.sv
verilog/nr_sync_top.sv
verif/nr_sync_checker.sv
verif/nr_sync_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the NR sync front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert -f tb.f --top-module nr_sync_tb \
    -Mdir obj_dir -o nr_sync_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/nr_sync_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

grep -q "Test failed" sim.log && exit 1 || exit 0

// ==== verif/nr_sync_trace.txt ====
# columns: command, then a number, or a check name and a number
# T name, R reset, S n stream, H n stream with FFT hold, W n idle, G random idle
# N v N_id_2 pulse, I v ibar pulse, D wait until FFT output idle, C name value check
T reset
W 4
C mode 0
C synced 0
C pbch 0
C ovf 0
C fftcnt 0
T pss_mode
N 0
W 1
C mode 2
W 517
C mode 2
C pbch 1
W 2
C mode 1
W 29
C mode 1
W 1
C mode 0
R
T prefix
N 1
W 2
I 1
W 2
C synced 1
S 536
D
C fftcnt 448
T tracking
N 1
W 2
C pbch 2
C synced 1
S 536
S 4
W 3
C synced 0
D
R
T hold
N 2
W 2
I 1
W 2
S 40
H 12
G
H 12
G
S 40
D
C ovf 0
T overflow
H 60
D
C ovf 1
